/* include/extbus_consts.svh */
`ifndef EXTBUS_CONSTS_SVH
`define EXTBUS_CONSTS_SVH

// Bus widths
`define ADDR_W 16
`define DATA_W 16
`define BYTE_W 8

// UART register map
`define UART_DATA_ADDR 16'hBF00
`define UART_STAT_ADDR 16'hBF01

// Receive queue, must be a power of two
`define RXQ_DEPTH 8

// Status word bits
`define STAT_RX_AVAIL 0
`define STAT_TX_IDLE 1

`endif

/* rtl/extbus_pkg.sv */
`include "extbus_consts.svh"

package extbus_pkg;

	typedef logic [`ADDR_W-1:0] bus_addr_t;
	typedef logic [`DATA_W-1:0] bus_data_t;
	typedef logic [`BYTE_W-1:0] uart_byte_t;

	// Extra MSB tells full from empty
	typedef logic [$clog2(`RXQ_DEPTH):0] rxq_ptr_t;

	typedef struct packed {
		bus_addr_t addr;
		bus_data_t wdata;
		logic write;
	} mem_req_t;

	typedef struct packed {
		bus_data_t rdata;
		logic err;
	} mem_resp_t;

	// Pins toward SRAM and UART chip, strobes active low
	typedef struct packed {
		bus_addr_t addr;
		bus_data_t data_out;
		logic data_oe;
		logic ram_en_n;
		logic ram_oe_n;
		logic ram_we_n;
		logic uart_rdn;
		logic uart_wrn;
	} chip_bus_t;

	typedef enum logic [3:0] {
		S_IDLE,
		S_RAM_RD1,
		S_RAM_RD2,
		S_RAM_WR1,
		S_RAM_WR2,
		S_QRD,
		S_TX1,
		S_TX2,
		S_TX3,
		S_TX4,
		S_RX1,
		S_RX2
	} ctrl_state_t;

endpackage

/* rtl/rx_queue.sv */
`timescale 1ns/1ps
`include "extbus_consts.svh"

module rx_queue
	import extbus_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic push,
	input uart_byte_t push_data,
	input logic pop,

	output logic full,
	output logic empty,
	output uart_byte_t head
);

	localparam int IDX_W = $bits(rxq_ptr_t) - 1;

	uart_byte_t mem [`RXQ_DEPTH];

	rxq_ptr_t wr_ptr;
	rxq_ptr_t rd_ptr;

	////////////////////
	// Pointers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push && !full) wr_ptr <= wr_ptr + rxq_ptr_t'(1);
			if (pop && !empty) rd_ptr <= rd_ptr + rxq_ptr_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (push && !full) mem[wr_ptr[IDX_W-1:0]] <= push_data;
	end

	// Same index, MSB differs once the writer has wrapped
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[IDX_W] != rd_ptr[IDX_W]) &&
		(wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);

	assign head = mem[rd_ptr[IDX_W-1:0]];

	////////////////////
	// Checks

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> !full)
		else $error("push into full receive queue");

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> !empty)
		else $error("pop from empty receive queue");

endmodule

/* rtl/ext_bus_ctrl.sv */
`timescale 1ns/1ps
`include "extbus_consts.svh"

module ext_bus_ctrl
	import extbus_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic req_valid,
	input mem_req_t req,
	output logic req_ready,
	output logic resp_valid,
	output mem_resp_t resp,

	output chip_bus_t chip,
	input bus_data_t data_in,
	input logic data_ready,
	input logic tbre,
	input logic tsre,

	input logic rxq_full,
	input logic rxq_empty,
	input uart_byte_t rxq_head,
	output logic rxq_push,
	output uart_byte_t rxq_push_data,
	output logic rxq_pop
);

	ctrl_state_t state;

	logic resp_valid_q;
	mem_resp_t resp_q;

	bus_addr_t addr_q;
	bus_data_t dout_q;
	logic data_oe_q;
	logic ram_en_n_q;
	logic ram_oe_n_q;
	logic ram_we_n_q;
	logic uart_rdn_q;
	logic uart_wrn_q;

	uart_byte_t rx_byte_q;

	logic cap_start;
	logic req_fire;
	logic is_uart_data;
	logic is_uart_stat;
	bus_data_t stat_word;

	////////////////////
	// Decode

	assign is_uart_data = (req.addr == `UART_DATA_ADDR);
	assign is_uart_stat = (req.addr == `UART_STAT_ADDR);

	// Capture wins over a waiting request
	assign cap_start = data_ready && !rxq_full;
	assign req_ready = (state == S_IDLE) && !cap_start;
	assign req_fire = req_valid && req_ready;

	always_comb begin
		stat_word = '0;
		stat_word[`STAT_RX_AVAIL] = !rxq_empty;
		stat_word[`STAT_TX_IDLE] = tbre & tsre;
	end

	////////////////////
	// Sequencer

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			resp_valid_q <= 1'b0;
			data_oe_q <= 1'b0;
			ram_en_n_q <= 1'b1;
			ram_oe_n_q <= 1'b1;
			ram_we_n_q <= 1'b1;
			uart_rdn_q <= 1'b1;
			uart_wrn_q <= 1'b1;
		end else begin
			resp_valid_q <= 1'b0;
			case (state)
				S_IDLE: begin
					if (cap_start) begin
						uart_rdn_q <= 1'b0;
						state <= S_RX1;
					end else if (req_fire) begin
						if (is_uart_stat) begin
							resp_valid_q <= 1'b1;
						end else if (is_uart_data && req.write) begin
							data_oe_q <= 1'b1;
							state <= S_TX1;
						end else if (is_uart_data) begin
							state <= S_QRD;
						end else if (req.write) begin
							ram_en_n_q <= 1'b0;
							data_oe_q <= 1'b1;
							state <= S_RAM_WR1;
						end else begin
							ram_en_n_q <= 1'b0;
							state <= S_RAM_RD1;
						end
					end
				end

				S_RAM_RD1: begin
					ram_oe_n_q <= 1'b0;
					state <= S_RAM_RD2;
				end
				S_RAM_RD2: begin
					ram_en_n_q <= 1'b1;
					ram_oe_n_q <= 1'b1;
					resp_valid_q <= 1'b1;
					state <= S_IDLE;
				end

				S_RAM_WR1: begin
					ram_we_n_q <= 1'b0;
					state <= S_RAM_WR2;
				end
				S_RAM_WR2: begin
					ram_we_n_q <= 1'b1;
					ram_en_n_q <= 1'b1;
					data_oe_q <= 1'b0;
					resp_valid_q <= 1'b1;
					state <= S_IDLE;
				end

				S_QRD: begin
					resp_valid_q <= 1'b1;
					state <= S_IDLE;
				end

				// Hold wrn low until the UART takes the byte
				S_TX1: begin
					uart_wrn_q <= 1'b0;
					state <= S_TX2;
				end
				S_TX2: begin
					if (!tbre) begin
						uart_wrn_q <= 1'b1;
						state <= S_TX3;
					end
				end
				S_TX3: begin
					if (tbre) state <= S_TX4;
				end
				S_TX4: begin
					if (tsre) begin
						data_oe_q <= 1'b0;
						resp_valid_q <= 1'b1;
						state <= S_IDLE;
					end
				end

				S_RX1: begin
					state <= S_RX2;
				end
				S_RX2: begin
					uart_rdn_q <= 1'b1;
					state <= S_IDLE;
				end

				default: state <= S_IDLE;
			endcase
		end
	end

	////////////////////
	// Payload

	always_ff @(posedge clk) begin
		if (req_fire) begin
			addr_q <= req.addr;
			dout_q <= req.wdata;
		end

		if (state == S_RX1) rx_byte_q <= data_in[`BYTE_W-1:0];

		case (state)
			S_IDLE: begin
				if (req_fire) resp_q <= mem_resp_t'{rdata: stat_word, err: 1'b0};
			end
			S_RAM_RD2: resp_q <= mem_resp_t'{rdata: data_in, err: 1'b0};
			S_RAM_WR2: resp_q <= '0;
			S_QRD: begin
				if (rxq_empty)
					resp_q <= mem_resp_t'{rdata: '0, err: 1'b1};
				else
					resp_q <= mem_resp_t'{
						rdata: {{(`DATA_W-`BYTE_W){1'b0}}, rxq_head},
						err: 1'b0
					};
			end
			S_TX4: resp_q <= '0;
			default: resp_q <= resp_q;
		endcase
	end

	////////////////////
	// Outputs

	assign resp_valid = resp_valid_q;
	assign resp = resp_q;

	assign rxq_push = (state == S_RX2);
	assign rxq_push_data = rx_byte_q;
	assign rxq_pop = (state == S_QRD) && !rxq_empty;

	assign chip.addr = addr_q;
	assign chip.data_out = dout_q;
	assign chip.data_oe = data_oe_q;
	assign chip.ram_en_n = ram_en_n_q;
	assign chip.ram_oe_n = ram_oe_n_q;
	assign chip.ram_we_n = ram_we_n_q;
	assign chip.uart_rdn = uart_rdn_q;
	assign chip.uart_wrn = uart_wrn_q;

	////////////////////
	// Bus contention checks

	a_ram_oe_we: assert property (@(posedge clk) disable iff (!rst_n)
		!(!chip.ram_oe_n && !chip.ram_we_n))
		else $error("SRAM oe_n and we_n low together");

	a_uart_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
		!(!chip.uart_rdn && !chip.uart_wrn))
		else $error("UART rdn and wrn low together");

	// Chips drive the bus while these strobes are low
	a_bus_fight: assert property (@(posedge clk) disable iff (!rst_n)
		chip.data_oe |-> (chip.ram_oe_n && chip.uart_rdn))
		else $error("data_oe high while a chip drives the bus");

endmodule

/* rtl/extbus_top.sv */
`timescale 1ns/1ps

module extbus_top
	import extbus_pkg::*;
(
	input logic clk,
	input logic rst_n,

	// CPU side
	input logic req_valid,
	input mem_req_t req,
	output logic req_ready,
	output logic resp_valid,
	output mem_resp_t resp,

	// Board side
	output chip_bus_t chip,
	input bus_data_t data_in,
	input logic data_ready,
	input logic tbre,
	input logic tsre
);

	logic rxq_push;
	uart_byte_t rxq_push_data;
	logic rxq_pop;
	logic rxq_full;
	logic rxq_empty;
	uart_byte_t rxq_head;

	ext_bus_ctrl ctrl_i (
		.clk (clk),
		.rst_n (rst_n),
		.req_valid (req_valid),
		.req (req),
		.req_ready (req_ready),
		.resp_valid (resp_valid),
		.resp (resp),
		.chip (chip),
		.data_in (data_in),
		.data_ready (data_ready),
		.tbre (tbre),
		.tsre (tsre),
		.rxq_full (rxq_full),
		.rxq_empty (rxq_empty),
		.rxq_head (rxq_head),
		.rxq_push (rxq_push),
		.rxq_push_data (rxq_push_data),
		.rxq_pop (rxq_pop)
	);

	// Holds bytes captured from the UART until the CPU reads them
	rx_queue rxq_i (
		.clk (clk),
		.rst_n (rst_n),
		.push (rxq_push),
		.push_data (rxq_push_data),
		.pop (rxq_pop),
		.full (rxq_full),
		.empty (rxq_empty),
		.head (rxq_head)
	);

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk
);

	// 20 ns period
	initial clk = 1'b0;
	always #10 clk = ~clk;

endmodule

/* verif/ext_chip_model.sv */
`timescale 1ns/1ps

module ext_chip_model
	import extbus_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input chip_bus_t chip,
	output bus_data_t data_in,
	output logic data_ready,
	output logic tbre,
	output logic tsre,

	// Bytes arriving on the serial line
	input logic rx_inject,
	input uart_byte_t rx_inject_byte,

	// One pulse per byte taken by the transmitter
	output logic tx_strobe,
	output uart_byte_t tx_byte
);

	bus_data_t sram [0:65535];
	uart_byte_t rx_fifo [0:63];

	logic [6:0] rx_wr;
	logic [6:0] rx_rd;
	logic rdn_q;
	logic [2:0] tx_cnt;

	initial begin
		for (int i = 0; i < 65536; i++) sram[i] = '0;
	end

	// Ready stays low until the byte being read is consumed
	assign data_ready = (rx_wr != rx_rd) && rdn_q;

	////////////////////
	// Shared bus

	always_comb begin
		if (!chip.uart_rdn)
			data_in = {8'h00, rx_fifo[rx_rd[5:0]]};
		else if (!chip.ram_en_n && !chip.ram_oe_n)
			data_in = sram[chip.addr];
		else if (chip.data_oe)
			data_in = chip.data_out;
		else
			data_in = '1;  // pull-ups
	end

	always_ff @(posedge clk) begin
		if (!chip.ram_en_n && !chip.ram_we_n && chip.data_oe)
			sram[chip.addr] <= chip.data_out;
		if (rx_inject)
			rx_fifo[rx_wr[5:0]] <= rx_inject_byte;
	end

	////////////////////
	// UART

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_wr <= '0;
			rx_rd <= '0;
			rdn_q <= 1'b1;
			tbre <= 1'b1;
			tsre <= 1'b1;
			tx_cnt <= '0;
			tx_strobe <= 1'b0;
			tx_byte <= '0;
		end else begin
			rdn_q <= chip.uart_rdn;
			tx_strobe <= 1'b0;
			if (rx_inject) rx_wr <= rx_wr + 7'd1;
			// Byte is consumed when rdn goes back high
			if (!rdn_q && chip.uart_rdn) rx_rd <= rx_rd + 7'd1;

			if (!chip.uart_wrn && chip.data_oe && tbre) begin
				tbre <= 1'b0;
				tsre <= 1'b0;
				tx_cnt <= 3'd5;
				tx_strobe <= 1'b1;
				tx_byte <= chip.data_out[7:0];
			end else if (tx_cnt != 3'd0) begin
				tx_cnt <= tx_cnt - 3'd1;
				if (tx_cnt == 3'd3) tbre <= 1'b1;
				if (tx_cnt == 3'd1) tsre <= 1'b1;
			end
		end
	end

endmodule

/* verif/tb_extbus.sv */
`timescale 1ns/1ps
`include "extbus_consts.svh"

module tb_extbus
	import extbus_pkg::*;
();

	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic rst_n;
	logic req_valid;
	mem_req_t req;
	logic req_ready;
	logic resp_valid;
	mem_resp_t resp;
	chip_bus_t chip;
	bus_data_t data_in;
	logic data_ready;
	logic tbre;
	logic tsre;
	logic rx_inject;
	uart_byte_t rx_inject_byte;
	logic tx_strobe;
	uart_byte_t tx_byte;

	uart_byte_t tx_log [$];
	int pending;
	integer seed;
	integer fd;

	tb_clk_gen clk_gen_i (.clk(clk));

	ext_chip_model chip_i (
		.clk (clk),
		.rst_n (rst_n),
		.chip (chip),
		.data_in (data_in),
		.data_ready (data_ready),
		.tbre (tbre),
		.tsre (tsre),
		.rx_inject (rx_inject),
		.rx_inject_byte (rx_inject_byte),
		.tx_strobe (tx_strobe),
		.tx_byte (tx_byte)
	);

	extbus_top extbus_top_i (
		.clk (clk),
		.rst_n (rst_n),
		.req_valid (req_valid),
		.req (req),
		.req_ready (req_ready),
		.resp_valid (resp_valid),
		.resp (resp),
		.chip (chip),
		.data_in (data_in),
		.data_ready (data_ready),
		.tbre (tbre),
		.tsre (tsre)
	);

	always @(posedge clk) begin
		if (tx_strobe) tx_log.push_back(tx_byte);
	end

	////////////////////
	// Helpers

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input bus_data_t exp, input bus_data_t act);
		assert (exp == act)
			else stop_run($sformatf("** Error %s expected %h actual %h", name, exp, act));
	endtask

	task automatic idle_gap();
		int n;
		n = $unsigned($random(seed)) % 4;
		repeat (n) @(negedge clk);
	endtask

	// Called on a falling edge, returns on one
	task automatic bus_access(input bus_addr_t addr, input bus_data_t wdata,
		input logic write, output mem_resp_t r);
		int cycles;
		req_valid = 1'b1;
		req.addr = addr;
		req.wdata = wdata;
		req.write = write;
		cycles = 0;
		while (!req_ready) begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) stop_run("timeout waiting for req_ready");
		end
		@(negedge clk);
		req_valid = 1'b0;
		cycles = 0;
		while (!resp_valid) begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) stop_run("timeout waiting for resp_valid");
		end
		r = resp;
	endtask

	task automatic inject_byte(input uart_byte_t b);
		rx_inject = 1'b1;
		rx_inject_byte = b;
		@(negedge clk);
		rx_inject = 1'b0;
	endtask

	task automatic expect_tx(input string name, input uart_byte_t exp);
		int cycles;
		uart_byte_t got;
		cycles = 0;
		while (tx_log.size() == 0) begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) stop_run("timeout waiting for a transmitted byte");
		end
		got = tx_log.pop_front();
		check_value(name, bus_data_t'(exp), bus_data_t'(got));
	endtask

	////////////////////
	// Trace driven stimulus

	initial begin
		logic [7:0] op;
		logic [8*160-1:0] rest;
		bus_addr_t addr;
		bus_data_t data;
		bus_data_t expect_v;
		mem_resp_t r;
		int n;
		int line_no;
		string name;

		seed = 32'hf408;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		rx_inject = 1'b0;
		rx_inject_byte = '0;
		pending = 0;
		line_no = 0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		fd = $fopen("verif/extbus_trace.txt", "r");
		if (fd == 0) stop_run("cannot open verif/extbus_trace.txt");

		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", op);
			if (n != 1) break;
			line_no++;
			if (op == "#") begin
				n = $fgets(rest, fd);
				continue;
			end
			n = $fscanf(fd, "%h %h %h", addr, data, expect_v);
			if (n != 3) stop_run($sformatf("malformed trace line %0d", line_no));
			name = $sformatf("line%0d_addr_%h", line_no, addr);
			idle_gap();
			case (op)
				"W": begin
					bus_access(addr, data, 1'b1, r);
					check_value({name, "_err"}, '0, bus_data_t'(r.err));
				end
				"R": begin
					bus_access(addr, '0, 1'b0, r);
					check_value({name, "_rdata"}, expect_v, r.rdata);
					check_value({name, "_err"}, '0, bus_data_t'(r.err));
					if (addr == `UART_DATA_ADDR) pending--;
				end
				"E": begin
					bus_access(addr, '0, 1'b0, r);
					check_value({name, "_rdata"}, expect_v, r.rdata);
					check_value({name, "_err"}, 16'd1, bus_data_t'(r.err));
				end
				"S": begin
					// RX bit follows the count of bytes not yet read back
					expect_v[`STAT_RX_AVAIL] = (pending != 0);
					bus_access(addr, '0, 1'b0, r);
					check_value({name, "_status"}, expect_v, r.rdata);
				end
				"I": begin
					inject_byte(data[7:0]);
					pending++;
				end
				"T": expect_tx({name, "_tx"}, expect_v[7:0]);
				default: stop_run($sformatf("unknown op on trace line %0d", line_no));
			endcase
		end
		$fclose(fd);

		repeat (20) @(negedge clk);
		if (tx_log.size() != 0 || pending != 0) begin
			stop_run("transmitted or received bytes left unchecked at end of trace");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

/* verif/extbus_trace.txt */
# op addr data expect, all hex
# W write, R read, E read with err, S status, I inject rx byte, T sent byte
W 0010 1234 0000
W 0011 abcd 0000
W fffe 8001 0000
R 0010 0000 1234
R 0011 0000 abcd
R fffe 0000 8001
R 0444 0000 0000
S bf01 0000 0002
W bf00 0041 0000
W bf00 1242 0000
T 0000 0000 0041
T 0000 0000 0042
S bf01 0000 0002
I 0000 0061 0000
I 0000 0062 0000
I 0000 0063 0000
I 0000 0064 0000
I 0000 0065 0000
I 0000 0066 0000
I 0000 0067 0000
I 0000 0068 0000
I 0000 0069 0000
I 0000 006a 0000
I 0000 006b 0000
S bf01 0000 0002
R bf00 0000 0061
R bf00 0000 0062
R bf00 0000 0063
R bf00 0000 0064
R bf00 0000 0065
R bf00 0000 0066
R bf00 0000 0067
R bf00 0000 0068
R bf00 0000 0069
R bf00 0000 006a
R bf00 0000 006b
S bf01 0000 0002
E bf00 0000 0000
R 0010 0000 1234
W 0300 0f0f 0000
R 0300 0000 0f0f

/* compile.f */
+incdir+include
rtl/extbus_pkg.sv
rtl/rx_queue.sv
rtl/ext_bus_ctrl.sv
rtl/extbus_top.sv
verif/tb_clk_gen.sv
verif/ext_chip_model.sv
verif/tb_extbus.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_extbus -o tb_extbus
./obj_dir/tb_extbus
